// File: hdl/decode_pkg.sv
/* Decode stage shared types */
package decode_pkg;

    localparam int INSTR_W     = 32;
    localparam int PC_W        = 32;
    localparam int UUID_W      = 16;
    localparam int NW_W        = 2;  // Four warps
    localparam int NUM_THREADS = 4;
    localparam int REG_W       = 5;
    localparam int IMM_W       = 32;

    // Major opcodes
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_B     = 7'b1100011;
    localparam logic [6:0] OPC_L     = 7'b0000011;
    localparam logic [6:0] OPC_S     = 7'b0100011;
    localparam logic [6:0] OPC_FENCE = 7'b0001111;
    localparam logic [6:0] OPC_SYS   = 7'b1110011;
    localparam logic [6:0] OPC_EXT1  = 7'b0001011;  // Warp control, custom-0

    localparam logic [6:0] F7_MULDIV = 7'h01;

    typedef enum logic [1:0] {
        EX_NONE = 2'd0,
        EX_ALU  = 2'd1,
        EX_LSU  = 2'd2,
        EX_SFU  = 2'd3
    } ex_type_e;

    typedef logic [3:0] op_type_t;

    localparam op_type_t ALU_ADD   = 4'd0;
    localparam op_type_t ALU_SUB   = 4'd1;
    localparam op_type_t ALU_SLL   = 4'd2;
    localparam op_type_t ALU_SLT   = 4'd3;
    localparam op_type_t ALU_SLTU  = 4'd4;
    localparam op_type_t ALU_XOR   = 4'd5;
    localparam op_type_t ALU_SRL   = 4'd6;
    localparam op_type_t ALU_SRA   = 4'd7;
    localparam op_type_t ALU_OR    = 4'd8;
    localparam op_type_t ALU_AND   = 4'd9;
    localparam op_type_t ALU_LUI   = 4'd10;
    localparam op_type_t ALU_AUIPC = 4'd11;

    localparam op_type_t BR_EQ     = 4'd0;
    localparam op_type_t BR_NE     = 4'd1;
    localparam op_type_t BR_LT     = 4'd4;
    localparam op_type_t BR_GE     = 4'd5;
    localparam op_type_t BR_LTU    = 4'd6;
    localparam op_type_t BR_GEU    = 4'd7;
    localparam op_type_t BR_JAL    = 4'd8;
    localparam op_type_t BR_JALR   = 4'd9;
    localparam op_type_t BR_ECALL  = 4'd10;
    localparam op_type_t BR_EBREAK = 4'd11;
    localparam op_type_t BR_URET   = 4'd12;
    localparam op_type_t BR_SRET   = 4'd13;
    localparam op_type_t BR_MRET   = 4'd14;

    localparam op_type_t LSU_FENCE = 4'd15;

    localparam op_type_t SFU_TMC    = 4'd0;
    localparam op_type_t SFU_WSPAWN = 4'd1;
    localparam op_type_t SFU_SPLIT  = 4'd2;
    localparam op_type_t SFU_JOIN   = 4'd3;
    localparam op_type_t SFU_BAR    = 4'd4;
    localparam op_type_t SFU_PRED   = 4'd5;
    localparam op_type_t SFU_CSRRW  = 4'd8;
    localparam op_type_t SFU_CSRRS  = 4'd9;
    localparam op_type_t SFU_CSRRC  = 4'd10;

    typedef enum logic [1:0] {
        ALU_ARITH  = 2'd0,
        ALU_BRANCH = 2'd1,
        ALU_MULDIV = 2'd2
    } alu_xtype_e;

    // Argument views, all 36 bits wide
    typedef struct packed {
        alu_xtype_e       xtype;
        logic             use_pc;
        logic             use_imm;
        logic [IMM_W-1:0] imm;
    } alu_args_t;

    typedef struct packed {
        logic [22:0] pad;
        logic        is_store;
        logic [11:0] offset;
    } lsu_args_t;

    typedef struct packed {
        logic [17:0] pad;
        logic [11:0] addr;
        logic        use_imm;
        logic [4:0]  imm;
    } csr_args_t;

    typedef struct packed {
        logic [34:0] pad;
        logic        is_neg;
    } wctl_args_t;

    typedef union packed {
        alu_args_t  alu;
        lsu_args_t  lsu;
        csr_args_t  csr;
        wctl_args_t wctl;
    } op_args_t;

    typedef struct packed {
        logic [UUID_W-1:0]      uuid;
        logic [NW_W-1:0]        wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [PC_W-1:0]        pc;
        logic [INSTR_W-1:0]     instr;
    } fetch_t;

    typedef struct packed {
        logic [UUID_W-1:0]      uuid;
        logic [NW_W-1:0]        wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [PC_W-1:0]        pc;
        ex_type_e               ex_type;
        op_type_t               op_type;
        op_args_t               op_args;
        logic                   wb;
        logic [REG_W-1:0]       rd;
        logic [REG_W-1:0]       rs1;
        logic [REG_W-1:0]       rs2;
    } decode_t;

    typedef struct packed {
        logic [IMM_W-1:0] i_imm;
        logic [IMM_W-1:0] s_imm;
        logic [IMM_W-1:0] b_imm;
        logic [IMM_W-1:0] u_imm;
        logic [IMM_W-1:0] j_imm;
    } imm_set_t;

endpackage

// File: hdl/imm_gen.sv
/* Immediate generator */
module imm_gen (
    input  logic [decode_pkg::INSTR_W-1:0] instr,
    output decode_pkg::imm_set_t           imms
);

    logic [2:0] func3;
    logic       is_shift;

    assign func3    = instr[14:12];
    assign is_shift = (func3 == 3'd1) || (func3 == 3'd5);  // SLLI, SRLI, SRAI

    always_comb begin
        if (is_shift) begin
            imms.i_imm = {{(decode_pkg::IMM_W-5){1'b0}}, instr[24:20]};
        end else begin
            imms.i_imm = {{(decode_pkg::IMM_W-12){instr[31]}}, instr[31:20]};
        end
        imms.s_imm = {{(decode_pkg::IMM_W-12){instr[31]}}, instr[31:25], instr[11:7]};
        imms.b_imm = {{(decode_pkg::IMM_W-13){instr[31]}}, instr[31], instr[7],
                      instr[30:25], instr[11:8], 1'b0};
        // Upper 20 bits, low 12 cleared
        imms.u_imm = {{(decode_pkg::IMM_W-31){instr[31]}}, instr[30:12], 12'b0};
        imms.j_imm = {{(decode_pkg::IMM_W-21){instr[31]}}, instr[31], instr[19:12],
                      instr[20], instr[30:21], 1'b0};
    end

endmodule

// File: hdl/func_decode.sv
/* Function field decode */
module func_decode (
    input  logic [decode_pkg::INSTR_W-1:0] instr,
    output decode_pkg::op_type_t           alu_op,
    output decode_pkg::op_type_t           br_op,
    output decode_pkg::op_type_t           sys_op,
    output decode_pkg::op_type_t           md_op
);

    logic [2:0]  func3;
    logic        f7_b5;
    logic        is_reg;
    logic [11:0] sys_field;

    assign func3     = instr[14:12];
    assign f7_b5     = instr[30];
    assign is_reg    = instr[5];  // Set for OPC_R, clear for OPC_I
    assign sys_field = instr[31:20];

    always_comb begin
        case (func3)
            3'd0:    alu_op = (is_reg && f7_b5) ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
            3'd1:    alu_op = decode_pkg::ALU_SLL;
            3'd2:    alu_op = decode_pkg::ALU_SLT;
            3'd3:    alu_op = decode_pkg::ALU_SLTU;
            3'd4:    alu_op = decode_pkg::ALU_XOR;
            3'd5:    alu_op = f7_b5 ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
            3'd6:    alu_op = decode_pkg::ALU_OR;
            default: alu_op = decode_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (func3)
            3'd1:    br_op = decode_pkg::BR_NE;
            3'd4:    br_op = decode_pkg::BR_LT;
            3'd5:    br_op = decode_pkg::BR_GE;
            3'd6:    br_op = decode_pkg::BR_LTU;
            3'd7:    br_op = decode_pkg::BR_GEU;
            default: br_op = decode_pkg::BR_EQ;  // 2 and 3 are reserved
        endcase
    end

    always_comb begin
        case (sys_field)
            12'h001: sys_op = decode_pkg::BR_EBREAK;
            12'h002: sys_op = decode_pkg::BR_URET;
            12'h102: sys_op = decode_pkg::BR_SRET;
            12'h302: sys_op = decode_pkg::BR_MRET;
            default: sys_op = decode_pkg::BR_ECALL;
        endcase
    end

    // MUL through REMU in func3 order
    assign md_op = {1'b0, func3};

endmodule

// File: hdl/warp_ctl_decode.sv
/* Warp control decode */
module warp_ctl_decode (
    input  logic [decode_pkg::INSTR_W-1:0] instr,
    output logic                           valid_op,
    output decode_pkg::op_type_t           op,
    output logic                           use_rd,
    output logic                           use_rs1,
    output logic                           use_rs2,
    output logic                           is_neg
);

    logic [2:0] func3;
    logic [6:0] func7;

    assign func3 = instr[14:12];
    assign func7 = instr[31:25];

    always_comb begin
        valid_op = (func7 == 7'h00) && (func3 <= 3'd5);
        op       = {1'b0, func3};  // TMC..PRED follow func3
        use_rd   = 1'b0;
        use_rs1  = valid_op;       // Every warp op reads rs1
        use_rs2  = 1'b0;
        is_neg   = 1'b0;
        if (valid_op) begin
            case (func3)
                3'd1, 3'd4: begin  // WSPAWN, BAR
                    use_rs2 = 1'b1;
                end
                3'd2: begin
                    use_rd = 1'b1;
                    is_neg = instr[20];
                end
                3'd5: begin
                    use_rs2 = 1'b1;
                    is_neg  = instr[7];
                end
                default: ;
            endcase
        end
    end

endmodule

// File: hdl/instr_decoder.sv
/* Instruction decoder */
module instr_decoder (
    input  decode_pkg::fetch_t  fetch,
    output decode_pkg::decode_t dec,
    output logic                wstall
);

    logic [6:0]                  opcode;
    logic [2:0]                  func3;
    logic [6:0]                  func7;
    logic [decode_pkg::REG_W-1:0] rd_f;
    logic [decode_pkg::REG_W-1:0] rs1_f;
    logic [decode_pkg::REG_W-1:0] rs2_f;

    decode_pkg::imm_set_t  imms;
    decode_pkg::op_type_t  alu_op;
    decode_pkg::op_type_t  br_op;
    decode_pkg::op_type_t  sys_op;
    decode_pkg::op_type_t  md_op;
    logic                  wctl_valid;
    decode_pkg::op_type_t  wctl_op;
    logic                  wctl_rd;
    logic                  wctl_rs1;
    logic                  wctl_rs2;
    logic                  wctl_neg;

    decode_pkg::ex_type_e ex_type;
    decode_pkg::op_type_t op_type;
    decode_pkg::op_args_t op_args;
    logic                 use_rd;
    logic                 use_rs1;
    logic                 use_rs2;

    assign opcode = fetch.instr[6:0];
    assign func3  = fetch.instr[14:12];
    assign func7  = fetch.instr[31:25];
    assign rd_f   = fetch.instr[11:7];
    assign rs1_f  = fetch.instr[19:15];
    assign rs2_f  = fetch.instr[24:20];

    imm_gen u_imm_gen (
        .instr (fetch.instr),
        .imms  (imms)
    );

    func_decode u_func_decode (
        .instr  (fetch.instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .sys_op (sys_op),
        .md_op  (md_op)
    );

    warp_ctl_decode u_warp_ctl_decode (
        .instr    (fetch.instr),
        .valid_op (wctl_valid),
        .op       (wctl_op),
        .use_rd   (wctl_rd),
        .use_rs1  (wctl_rs1),
        .use_rs2  (wctl_rs2),
        .is_neg   (wctl_neg)
    );

    always_comb begin
        ex_type = decode_pkg::EX_NONE;
        op_type = '0;
        op_args = '0;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        wstall  = 1'b0;
        case (opcode)
            decode_pkg::OPC_I, decode_pkg::OPC_R: begin
                ex_type = decode_pkg::EX_ALU;
                op_type = alu_op;
                op_args.alu.xtype = decode_pkg::ALU_ARITH;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                if (opcode == decode_pkg::OPC_I) begin
                    op_args.alu.use_imm = 1'b1;
                    op_args.alu.imm     = imms.i_imm;
                end else begin
                    use_rs2 = 1'b1;
                    if (func7 == decode_pkg::F7_MULDIV) begin
                        op_type = md_op;
                        op_args.alu.xtype = decode_pkg::ALU_MULDIV;
                    end
                end
            end
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
                ex_type = decode_pkg::EX_ALU;
                op_type = opcode[5] ? decode_pkg::ALU_LUI : decode_pkg::ALU_AUIPC;
                op_args.alu.xtype   = decode_pkg::ALU_ARITH;
                op_args.alu.use_pc  = ~opcode[5];
                op_args.alu.use_imm = 1'b1;
                op_args.alu.imm     = imms.u_imm;
                use_rd = 1'b1;
            end
            decode_pkg::OPC_JAL, decode_pkg::OPC_JALR, decode_pkg::OPC_B: begin
                ex_type = decode_pkg::EX_ALU;
                op_args.alu.xtype   = decode_pkg::ALU_BRANCH;
                op_args.alu.use_imm = 1'b1;
                wstall = 1'b1;
                if (opcode == decode_pkg::OPC_JAL) begin
                    op_type = decode_pkg::BR_JAL;
                    op_args.alu.use_pc = 1'b1;
                    op_args.alu.imm    = imms.j_imm;
                    use_rd = 1'b1;
                end else if (opcode == decode_pkg::OPC_JALR) begin
                    op_type = decode_pkg::BR_JALR;
                    op_args.alu.imm = imms.i_imm;
                    use_rd  = 1'b1;
                    use_rs1 = 1'b1;
                end else begin
                    op_type = br_op;
                    op_args.alu.use_pc = 1'b1;
                    op_args.alu.imm    = imms.b_imm;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            decode_pkg::OPC_L: begin
                ex_type = decode_pkg::EX_LSU;
                op_type = {1'b0, func3};
                op_args.lsu.offset = fetch.instr[31:20];
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            decode_pkg::OPC_S: begin
                ex_type = decode_pkg::EX_LSU;
                op_type = {1'b1, func3};
                op_args.lsu.is_store = 1'b1;
                op_args.lsu.offset   = imms.s_imm[11:0];
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            decode_pkg::OPC_FENCE: begin
                ex_type = decode_pkg::EX_LSU;
                op_type = decode_pkg::LSU_FENCE;
            end
            decode_pkg::OPC_SYS: begin
                use_rd = 1'b1;
                if (func3[1:0] != 2'd0) begin
                    // CSRRW/S/C map to 8, 9, 10
                    ex_type = decode_pkg::EX_SFU;
                    op_type = {2'b10, 2'(func3[1:0] - 2'd1)};
                    op_args.csr.addr    = fetch.instr[31:20];
                    op_args.csr.use_imm = func3[2];
                    op_args.csr.imm     = rs1_f;
                    use_rs1 = ~func3[2];
                end else begin
                    ex_type = decode_pkg::EX_ALU;
                    op_type = sys_op;
                    op_args.alu.xtype   = decode_pkg::ALU_BRANCH;
                    op_args.alu.use_pc  = 1'b1;
                    op_args.alu.use_imm = 1'b1;
                    op_args.alu.imm     = decode_pkg::IMM_W'(4);  // Return address offset
                    wstall = 1'b1;
                end
            end
            decode_pkg::OPC_EXT1: begin
                if (wctl_valid) begin
                    ex_type = decode_pkg::EX_SFU;
                    op_type = wctl_op;
                    op_args.wctl.is_neg = wctl_neg;
                    use_rd  = wctl_rd;
                    use_rs1 = wctl_rs1;
                    use_rs2 = wctl_rs2;
                    wstall  = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign dec = '{
        uuid:    fetch.uuid,
        wid:     fetch.wid,
        tmask:   fetch.tmask,
        pc:      fetch.pc,
        ex_type: ex_type,
        op_type: op_type,
        op_args: op_args,
        wb:      use_rd && (rd_f != '0),  // x0 is never written
        rd:      use_rd ? rd_f : '0,
        rs1:     use_rs1 ? rs1_f : '0,
        rs2:     use_rs2 ? rs2_f : '0
    };

endmodule

// File: hdl/decode_buf.sv
/* Decode output buffer */
module decode_buf (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  decode_pkg::decode_t in_data,
    output logic                out_valid,
    input  logic                out_ready,
    output decode_pkg::decode_t out_data
);

    // Take a new entry whenever the current one leaves or the slot is empty
    assign in_ready = ~out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// File: hdl/decode_stage.sv
/* GPU decode stage */
module decode_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_valid,
    output logic                        fetch_ready,
    input  decode_pkg::fetch_t          fetch_data,
    output logic                        decode_valid,
    input  logic                        decode_ready,
    output decode_pkg::decode_t         decode_data,
    output logic                        sched_valid,
    output logic [decode_pkg::NW_W-1:0] sched_wid,
    output logic                        sched_unlock
);

    decode_pkg::decode_t dec;
    logic                wstall;

    instr_decoder u_instr_decoder (
        .fetch  (fetch_data),
        .dec    (dec),
        .wstall (wstall)
    );

    decode_buf u_decode_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (dec),
        .out_valid (decode_valid),
        .out_ready (decode_ready),
        .out_data  (decode_data)
    );

    // Scheduler hears about each accepted warp in the same cycle
    assign sched_valid  = fetch_valid && fetch_ready;
    assign sched_wid    = fetch_data.wid;
    assign sched_unlock = ~wstall;

endmodule

// File: sim/decode_ref.svh
/* Decode reference model */
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

function automatic logic [31:0] sign_ext(input logic [31:0] v, input int bits);
    logic signed [31:0] t;
    t = v << (32 - bits);
    return t >>> (32 - bits);
endfunction

// Control flow, non-CSR system and valid warp ops hold the warp
function automatic logic expect_unlock(input logic [31:0] ins);
    case (ins[6:0])
        decode_pkg::OPC_JAL, decode_pkg::OPC_JALR, decode_pkg::OPC_B: return 1'b0;
        decode_pkg::OPC_SYS: return ins[13:12] != 2'd0;
        decode_pkg::OPC_EXT1: return !(ins[31:25] == 7'd0 && ins[14:12] <= 3'd5);
        default: return 1'b1;
    endcase
endfunction

function automatic decode_pkg::decode_t expect_decode(input decode_pkg::fetch_t f);
    decode_pkg::decode_t   d;
    decode_pkg::alu_args_t a;
    logic [31:0]           ins;
    logic [2:0]            f3;
    logic [2:0]            regs;  // rd, rs1, rs2
    logic [31:0]           i_imm;
    ins   = f.instr;
    f3    = ins[14:12];
    d     = '0;
    a     = '0;
    regs  = 3'b000;
    i_imm = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, ins[24:20]} : sign_ext(ins[31:20], 12);
    d.uuid  = f.uuid;
    d.wid   = f.wid;
    d.tmask = f.tmask;
    d.pc    = f.pc;
    case (ins[6:0])
        decode_pkg::OPC_I, decode_pkg::OPC_R: begin
            d.ex_type = decode_pkg::EX_ALU;
            regs      = ins[5] ? 3'b111 : 3'b110;
            a.use_imm = !ins[5];
            a.imm     = ins[5] ? 32'd0 : i_imm;
            case (f3)
                3'd0: d.op_type = (ins[5] && ins[30]) ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
                3'd1: d.op_type = decode_pkg::ALU_SLL;
                3'd2: d.op_type = decode_pkg::ALU_SLT;
                3'd3: d.op_type = decode_pkg::ALU_SLTU;
                3'd4: d.op_type = decode_pkg::ALU_XOR;
                3'd5: d.op_type = ins[30] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
                3'd6: d.op_type = decode_pkg::ALU_OR;
                default: d.op_type = decode_pkg::ALU_AND;
            endcase
            if (ins[5] && ins[31:25] == decode_pkg::F7_MULDIV) begin
                d.op_type = {1'b0, f3};
                a.xtype   = decode_pkg::ALU_MULDIV;
            end
            d.op_args.alu = a;
        end
        decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
            d.ex_type = decode_pkg::EX_ALU;
            a.use_pc  = (ins[6:0] == decode_pkg::OPC_AUIPC);
            d.op_type = a.use_pc ? decode_pkg::ALU_AUIPC : decode_pkg::ALU_LUI;
            a.use_imm = 1'b1;
            a.imm     = {ins[31:12], 12'd0};
            d.op_args.alu = a;
            regs = 3'b100;
        end
        decode_pkg::OPC_JAL, decode_pkg::OPC_JALR, decode_pkg::OPC_B: begin
            d.ex_type = decode_pkg::EX_ALU;
            a.xtype   = decode_pkg::ALU_BRANCH;
            a.use_imm = 1'b1;
            a.use_pc  = (ins[6:0] != decode_pkg::OPC_JALR);
            if (ins[6:0] == decode_pkg::OPC_JAL) begin
                d.op_type = decode_pkg::BR_JAL;
                a.imm     = sign_ext({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}, 21);
                regs      = 3'b100;
            end else if (ins[6:0] == decode_pkg::OPC_JALR) begin
                d.op_type = decode_pkg::BR_JALR;
                a.imm     = i_imm;
                regs      = 3'b110;
            end else begin
                // Reserved func3 2 and 3 fall back to EQ
                d.op_type = (f3 == 3'd2 || f3 == 3'd3) ? decode_pkg::BR_EQ : {1'b0, f3};
                a.imm     = sign_ext({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}, 13);
                regs      = 3'b011;
            end
            d.op_args.alu = a;
        end
        decode_pkg::OPC_L: begin
            d.ex_type = decode_pkg::EX_LSU;
            d.op_type = {1'b0, f3};
            d.op_args.lsu.offset = ins[31:20];
            regs = 3'b110;
        end
        decode_pkg::OPC_S: begin
            d.ex_type = decode_pkg::EX_LSU;
            d.op_type = {1'b1, f3};
            d.op_args.lsu.is_store = 1'b1;
            d.op_args.lsu.offset   = {ins[31:25], ins[11:7]};
            regs = 3'b011;
        end
        decode_pkg::OPC_FENCE: begin
            d.ex_type = decode_pkg::EX_LSU;
            d.op_type = decode_pkg::LSU_FENCE;
        end
        decode_pkg::OPC_SYS: begin
            regs = 3'b100;
            if (f3[1:0] != 2'd0) begin
                d.ex_type = decode_pkg::EX_SFU;
                d.op_type = 4'd7 + f3[1:0];  // CSRRW, CSRRS, CSRRC
                d.op_args.csr.addr    = ins[31:20];
                d.op_args.csr.use_imm = f3[2];
                d.op_args.csr.imm     = ins[19:15];
                regs[1] = !f3[2];
            end else begin
                d.ex_type = decode_pkg::EX_ALU;
                case (ins[31:20])
                    12'h001: d.op_type = decode_pkg::BR_EBREAK;
                    12'h002: d.op_type = decode_pkg::BR_URET;
                    12'h102: d.op_type = decode_pkg::BR_SRET;
                    12'h302: d.op_type = decode_pkg::BR_MRET;
                    default: d.op_type = decode_pkg::BR_ECALL;
                endcase
                a.xtype   = decode_pkg::ALU_BRANCH;
                a.use_pc  = 1'b1;
                a.use_imm = 1'b1;
                a.imm     = 32'd4;
                d.op_args.alu = a;
            end
        end
        decode_pkg::OPC_EXT1: begin
            if (ins[31:25] == 7'd0 && f3 <= 3'd5) begin
                d.ex_type = decode_pkg::EX_SFU;
                d.op_type = {1'b0, f3};
                case (f3)
                    3'd2: begin
                        regs = 3'b110;
                        d.op_args.wctl.is_neg = ins[20];
                    end
                    3'd5: begin
                        regs = 3'b011;
                        d.op_args.wctl.is_neg = ins[7];
                    end
                    3'd1, 3'd4: regs = 3'b011;
                    default: regs = 3'b010;
                endcase
            end
        end
        default: ;
    endcase
    d.rd  = regs[2] ? ins[11:7] : 5'd0;
    d.rs1 = regs[1] ? ins[19:15] : 5'd0;
    d.rs2 = regs[0] ? ins[24:20] : 5'd0;
    d.wb  = regs[2] && (ins[11:7] != 5'd0);
    return d;
endfunction

`endif

// File: sim/decode_tb.sv
/* Decode stage testbench */
module decode_tb;

    localparam int NUM_RAND = 200;
    localparam logic [6:0] OPCODES [14] = '{
        decode_pkg::OPC_I, decode_pkg::OPC_R, decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC,
        decode_pkg::OPC_JAL, decode_pkg::OPC_JALR, decode_pkg::OPC_B, decode_pkg::OPC_L,
        decode_pkg::OPC_S, decode_pkg::OPC_FENCE, decode_pkg::OPC_SYS, decode_pkg::OPC_EXT1,
        7'h7F, 7'h5B
    };

    logic                        clk;
    logic                        rst;
    logic                        fetch_valid;
    logic                        fetch_ready;
    decode_pkg::fetch_t          fetch_data;
    logic                        decode_valid;
    logic                        decode_ready;
    decode_pkg::decode_t         decode_data;
    logic                        sched_valid;
    logic [decode_pkg::NW_W-1:0] sched_wid;
    logic                        sched_unlock;

    decode_pkg::decode_t exp_q[$];
    decode_pkg::decode_t exp_head;
    int                  exp_count;
    logic                exp_unlock;
    logic                idle_phase;
    logic [31:0]         prog[$];
    int                  prog_len;
    int                  sent;
    int                  received;

    `include "decode_ref.svh"

    decode_stage u_dut (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch_data   (fetch_data),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .decode_data  (decode_data),
        .sched_valid  (sched_valid),
        .sched_wid    (sched_wid),
        .sched_unlock (sched_unlock)
    );

    always #10 clk = ~clk;

    assign exp_unlock = expect_unlock(fetch_data.instr);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [127:0] exp,
                                input logic [127:0] act);
        stop_run($sformatf("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act));
    endtask

    function automatic logic [31:0] r_form(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_form(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    task automatic build_program();
        logic [2:0]  f3;
        logic [31:0] instr;
        for (int k = 0; k < 8; k++) begin
            f3 = 3'(k);
            prog.push_back(r_form(7'h00, 5'd3, 5'd2, f3, 5'd1, decode_pkg::OPC_R));
            prog.push_back(r_form(7'h20, 5'd4, 5'd5, f3, 5'd6, decode_pkg::OPC_R));
            prog.push_back(r_form(decode_pkg::F7_MULDIV, 5'd7, 5'd8, f3, 5'd9,
                                  decode_pkg::OPC_R));
            prog.push_back(i_form(12'hF85, 5'd10, f3, 5'd11, decode_pkg::OPC_I));  // SRAI too
            prog.push_back(i_form(12'h07F, 5'd10, f3, 5'd0, decode_pkg::OPC_I));   // rd is x0
            prog.push_back(r_form(7'h5A, 5'd12, 5'd13, f3, 5'd14, decode_pkg::OPC_B));
            prog.push_back(i_form(12'h8F3, 5'd15, f3, 5'd16, decode_pkg::OPC_L));
            prog.push_back(r_form(7'h41, 5'd17, 5'd18, f3, 5'h1D, decode_pkg::OPC_S));
            prog.push_back(i_form(12'h340, 5'd19, f3, 5'd20, decode_pkg::OPC_SYS));
            prog.push_back(r_form(7'h00, 5'd21, 5'd22, f3, 5'd23, decode_pkg::OPC_EXT1));
            prog.push_back(r_form(7'h00, 5'd20, 5'd22, f3, 5'd0, decode_pkg::OPC_EXT1));
            prog.push_back(r_form(7'h10, 5'd21, 5'd22, f3, 5'd23, decode_pkg::OPC_EXT1));
        end
        // ECALL, EBREAK, the xRETs and an unlisted system field
        prog.push_back(i_form(12'h000, 5'd0, 3'd0, 5'd0, decode_pkg::OPC_SYS));
        prog.push_back(i_form(12'h001, 5'd0, 3'd0, 5'd0, decode_pkg::OPC_SYS));
        prog.push_back(i_form(12'h002, 5'd0, 3'd0, 5'd0, decode_pkg::OPC_SYS));
        prog.push_back(i_form(12'h102, 5'd0, 3'd0, 5'd0, decode_pkg::OPC_SYS));
        prog.push_back(i_form(12'h302, 5'd0, 3'd0, 5'd0, decode_pkg::OPC_SYS));
        prog.push_back(i_form(12'h7FF, 5'd3, 3'd0, 5'd1, decode_pkg::OPC_SYS));
        prog.push_back(i_form(12'h800, 5'd3, 3'd5, 5'd4, decode_pkg::OPC_LUI));
        prog.push_back(i_form(12'h9AB, 5'd7, 3'd2, 5'd5, decode_pkg::OPC_AUIPC));
        prog.push_back(i_form(12'hC01, 5'd9, 3'd6, 5'd1, decode_pkg::OPC_JAL));
        prog.push_back(i_form(12'hFF0, 5'd2, 3'd0, 5'd1, decode_pkg::OPC_JALR));
        prog.push_back(i_form(12'h0FF, 5'd0, 3'd0, 5'd0, decode_pkg::OPC_FENCE));
        prog.push_back(i_form(12'h123, 5'd4, 3'd1, 5'd5, 7'h7F));
        repeat (NUM_RAND) begin
            instr      = $urandom;
            instr[6:0] = OPCODES[$urandom_range(13)];
            prog.push_back(instr);
        end
        prog_len = prog.size();
    endtask

    task automatic send_instr(input logic [31:0] instr);
        logic taken;
        while ($urandom_range(3) == 0) begin
            @(posedge clk);
            #1;
        end
        fetch_valid      = 1'b1;
        fetch_data.uuid  = 16'(sent);
        fetch_data.wid   = 2'($urandom);
        fetch_data.tmask = 4'($urandom);
        fetch_data.pc    = $urandom & 32'hFFFF_FFFC;
        fetch_data.instr = instr;
        do begin
            @(negedge clk);
            taken = fetch_ready;
            @(posedge clk);
            #1;
        end while (!taken);
        fetch_valid = 1'b0;
        sent++;
    endtask

    // Scoreboard of accepted instructions awaiting transfer
    always @(posedge clk) begin
        if (!rst) begin
            if (decode_valid && decode_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
                received++;
            end
            if (fetch_valid && fetch_ready) begin
                exp_q.push_back(expect_decode(fetch_data));
            end
            exp_count <= exp_q.size();
            exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (rst)
        idle_phase |-> (!decode_valid && !sched_valid && fetch_ready))
        else stop_run("DUT left its idle state after reset with no input applied");

    a_data: assert property (@(posedge clk) disable iff (rst)
        decode_valid |-> (exp_count != 0 && decode_data == exp_head))
        else report_value("decode_data", $sampled(exp_head), $sampled(decode_data));

    a_hold: assert property (@(posedge clk) disable iff (rst)
        (decode_valid && !decode_ready) |=> (decode_valid && $stable(decode_data)))
        else stop_run("Held record changed or vanished under back-pressure");

    a_ready: assert property (@(posedge clk) disable iff (rst)
        fetch_ready == (!decode_valid || decode_ready))
        else report_value("fetch_ready", $sampled(!decode_valid || decode_ready),
                          $sampled(fetch_ready));

    a_sched: assert property (@(posedge clk) disable iff (rst)
        sched_valid == (fetch_valid && fetch_ready))
        else report_value("sched_valid", $sampled(fetch_valid && fetch_ready),
                          $sampled(sched_valid));

    a_wid: assert property (@(posedge clk) disable iff (rst)
        sched_valid |-> (sched_wid == fetch_data.wid))
        else report_value("sched_wid", $sampled(fetch_data.wid), $sampled(sched_wid));

    a_unlock: assert property (@(posedge clk) disable iff (rst)
        sched_valid |-> (sched_unlock == exp_unlock))
        else report_value("sched_unlock", $sampled(exp_unlock), $sampled(sched_unlock));

    initial begin
        wait (prog_len != 0);
        #((prog_len * 40 + 20) * 20);
        stop_run("Watchdog timeout: records stopped leaving the decode stage");
    end

    initial begin
        void'($urandom(59));
        clk          = 1'b0;
        rst          = 1'b1;
        fetch_valid  = 1'b0;
        fetch_data   = '0;
        decode_ready = 1'b0;
        idle_phase   = 1'b0;
        exp_count    = 0;
        exp_head     = '0;
        prog_len     = 0;
        sent         = 0;
        received     = 0;
        repeat (8) @(posedge clk);
        #1;
        rst        = 1'b0;
        idle_phase = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        idle_phase = 1'b0;
        fork
            forever begin
                decode_ready = ($urandom_range(3) != 0);  // Random issue stalls
                @(posedge clk);
                #1;
            end
        join_none
        build_program();
        foreach (prog[i]) begin
            send_instr(prog[i]);
        end
        while (received < sent) begin
            @(posedge clk);
            #1;
        end
        // Nothing accepted after the last record, so the slot must be empty
        if (!decode_valid) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_run($sformatf("Extra record on decode output after all %0d records left",
                               received));
        end
    end

endmodule

// File: decode_stage.f
+incdir+sim
hdl/decode_pkg.sv
hdl/imm_gen.sv
hdl/func_decode.sv
hdl/warp_ctl_decode.sv
hdl/instr_decoder.sv
hdl/decode_buf.sv
hdl/decode_stage.sv
sim/decode_tb.sv
